// File: design/instrClassify.sv
`timescale 1ns/1ps
`default_nettype none

module instrClassify (
  input  wire predecPkg::parcelT     parcel,
  output      predecPkg::instrClassE cls
);

  import predecPkg::*;

  logic [7:0] opcode;
  logic       isAlu;
  logic       isLdSt;
  logic       isShift;
  logic       isMul;
  logic       isJump;
  logic       isSys;

  assign opcode = parcel[7:0];

  assign isAlu   = opcode[7:6] == 2'b00;                // 0x00-0x3f.
  assign isLdSt  = opcode[7:5] == 3'b010;               // 0x40-0x5f.
  assign isShift = opcode[7:4] == 4'b0110;              // 0x60-0x6f.
  assign isMul   = opcode[7:3] == 5'b01110;             // 0x70-0x77.
  assign isSys   = &opcode;

  // 0xa0-0xb5 only, the top of that block is unused.
  assign isJump  = opcode[7:5] == 3'b101 && opcode[4:0] <= 5'h15;

  always_comb begin
    if (isAlu) begin
      cls = clsAlu;
    end else if (isLdSt) begin
      cls = opcode[0] ? clsStore : clsLoad;  // Odd is store.
    end else if (isShift) begin
      cls = clsShift;
    end else if (isMul) begin
      cls = clsMul;
    end else if (isJump) begin
      cls = clsJump;
    end else if (isSys) begin
      cls = clsSys;
    end else begin
      cls = clsNone;
    end
  end

endmodule

`default_nettype wire

// File: design/predecPkg.sv
`default_nettype none

package predecPkg;

  localparam int ParcelW      = 16;
  localparam int NumParcels   = 8;
  localparam int InstrW       = 48;  // Three parcels.
  localparam int OffW         = 3;
  localparam int NumSlots     = 4;
  localparam int NumJumpSlots = 2;
  localparam int RankW        = 4;   // Holds 0 to NumParcels.

  typedef logic [ParcelW-1:0] parcelT;

  typedef parcelT [NumParcels-1:0] bundleT;

  // One bit per parcel position.
  typedef logic [NumParcels-1:0] parcelMaskT;

  typedef enum logic [2:0] {
    clsNone,
    clsAlu,
    clsLoad,
    clsStore,
    clsShift,
    clsMul,
    clsJump,
    clsSys
  } instrClassE;

  typedef instrClassE [NumParcels-1:0] classVecT;

  // Rank of position k is the count of marked positions below k.
  typedef logic [NumParcels-1:0][RankW-1:0] rankVecT;

  typedef struct packed {
    logic              valid;
    instrClassE        cls;
    logic [OffW-1:0]   off;    // Parcel offset in bundle.
    logic [InstrW-1:0] instr;  // Parcels off, off+1, off+2.
  } slotT;

endpackage

`default_nettype wire

// File: design/predecoder.sv
`timescale 1ns/1ps
`default_nettype none

module predecoder (
  input  wire                                                clk,
  input  wire                                                rstN,
  input  wire                                                inValid,
  input  wire predecPkg::bundleT                             bundle,
  input  wire predecPkg::parcelMaskT                         endBits,
  input  wire [predecPkg::OffW-1:0]                          startOff,
  output logic                                               outValid,
  output predecPkg::slotT [predecPkg::NumSlots-1:0]          slots,
  output predecPkg::slotT [predecPkg::NumJumpSlots-1:0]      jumpSlots,
  output logic                                               hasJumps,
  output logic                                               error,
  output logic                                               jumpOverflow
);

  import predecPkg::*;

  classVecT   classVec;
  parcelMaskT startMask;
  parcelMaskT jumpMask;
  rankVecT    startRank;
  rankVecT    jumpRank;

  // One classifier per parcel, only starts are used later.
  for (genvar k = 0; k < NumParcels; k++) begin : gCls
    instrClassify cls0 (
      .parcel (bundle[k]),
      .cls    (classVec[k])
    );
  end

  startCounter cnt0 (
    .clk          (clk),
    .rstN         (rstN),
    .inValid      (inValid),
    .endBits      (endBits),
    .startOff     (startOff),
    .classVec     (classVec),
    .startMask    (startMask),
    .jumpMask     (jumpMask),
    .startRank    (startRank),
    .jumpRank     (jumpRank),
    .outValid     (outValid),
    .hasJumps     (hasJumps),
    .error        (error),
    .jumpOverflow (jumpOverflow)
  );

  slotSelect #(
    .NumOut (NumSlots)
  ) instrSel0 (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .bundle   (bundle),
    .classVec (classVec),
    .selMask  (startMask),
    .rank     (startRank),
    .slotOut  (slots)
  );

  slotSelect #(
    .NumOut (NumJumpSlots)
  ) jumpSel0 (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .bundle   (bundle),
    .classVec (classVec),
    .selMask  (jumpMask),
    .rank     (jumpRank),
    .slotOut  (jumpSlots)
  );

endmodule

`default_nettype wire

// File: design/slotSelect.sv
`timescale 1ns/1ps
`default_nettype none

module slotSelect #(
  parameter int NumOut = 4
) (
  input  wire                             clk,
  input  wire                             rstN,
  input  wire                             inValid,
  input  wire predecPkg::bundleT          bundle,
  input  wire predecPkg::classVecT        classVec,
  input  wire predecPkg::parcelMaskT      selMask,
  input  wire predecPkg::rankVecT         rank,
  output      predecPkg::slotT [NumOut-1:0] slotOut
);

  import predecPkg::*;

  // Zero parcels past the end so every start can read three.
  logic [NumParcels*ParcelW+InstrW-ParcelW-1:0] bundleExt;
  logic [NumOut-1:0][NumParcels-1:0]            hit;
  slotT [NumOut-1:0]                            slotNext;
  slotT [NumOut-1:0]                            payloadQ;
  logic [NumOut-1:0]                            validQ;

  assign bundleExt = {{(InstrW - ParcelW){1'b0}}, bundle};

  always_comb begin
    for (int n = 0; n < NumOut; n++) begin
      slotNext[n] = '0;
      for (int k = 0; k < NumParcels; k++) begin
        hit[n][k] = selMask[k] && (rank[k] == RankW'(n));
        if (hit[n][k]) begin
          slotNext[n].valid = 1'b1;
          slotNext[n].cls   = classVec[k];
          slotNext[n].off   = OffW'(k);
          slotNext[n].instr = bundleExt[k*ParcelW +: InstrW];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= '0;
    end else if (inValid) begin
      for (int n = 0; n < NumOut; n++) begin
        validQ[n] <= slotNext[n].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      payloadQ <= slotNext;
    end
  end

  always_comb begin
    slotOut = payloadQ;
    for (int n = 0; n < NumOut; n++) begin
      slotOut[n].valid = validQ[n];
    end
  end

  // Ranks from the counter are unique per marked position.
  for (genvar n = 0; n < NumOut; n++) begin : gHitChk
    assert property (@(posedge clk) disable iff (!rstN)
      inValid |-> $onehot0(hit[n]));
  end

endmodule

`default_nettype wire

// File: design/startCounter.sv
`timescale 1ns/1ps
`default_nettype none

module startCounter (
  input  wire                             clk,
  input  wire                             rstN,
  input  wire                             inValid,
  input  wire predecPkg::parcelMaskT      endBits,
  input  wire [predecPkg::OffW-1:0]       startOff,
  input  wire predecPkg::classVecT        classVec,
  output      predecPkg::parcelMaskT      startMask,
  output      predecPkg::parcelMaskT      jumpMask,
  output      predecPkg::rankVecT         startRank,
  output      predecPkg::rankVecT         jumpRank,
  output logic                            outValid,
  output logic                            hasJumps,
  output logic                            error,
  output logic                            jumpOverflow
);

  import predecPkg::*;

  parcelMaskT       prevEnd;   // Previous parcel closed an instruction.
  parcelMaskT       endAbove;  // An end bit at k or above.
  logic [RankW-1:0] startCnt;
  logic [RankW-1:0] jumpCnt;

  assign prevEnd = {endBits[NumParcels-2:0], 1'b1};

  always_comb begin
    endAbove[NumParcels-1] = endBits[NumParcels-1];
    for (int k = NumParcels - 2; k >= 0; k--) begin
      endAbove[k] = endBits[k] | endAbove[k+1];
    end
    for (int k = 0; k < NumParcels; k++) begin
      startMask[k] = (k >= int'(startOff)) && prevEnd[k] && endAbove[k];
      jumpMask[k]  = startMask[k] && (classVec[k] == clsJump);
    end
  end

  // Prefix popcount with the totals left at the end.
  always_comb begin
    startCnt = '0;
    jumpCnt  = '0;
    for (int k = 0; k < NumParcels; k++) begin
      startRank[k] = startCnt;
      jumpRank[k]  = jumpCnt;
      startCnt     = startCnt + RankW'(startMask[k]);
      jumpCnt      = jumpCnt + RankW'(jumpMask[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid     <= 1'b0;
      hasJumps     <= 1'b0;
      error        <= 1'b0;
      jumpOverflow <= 1'b0;
    end else begin
      outValid <= inValid;  // One pulse per strobe.
      if (inValid) begin
        hasJumps     <= jumpCnt != '0;
        error        <= startCnt > RankW'(NumSlots);
        jumpOverflow <= jumpCnt > RankW'(NumJumpSlots);
      end
    end
  end

  // Each start owns a distinct end bit at or above it.
  assert property (@(posedge clk) disable iff (!rstN)
    inValid |-> startCnt <= RankW'($countones(endBits)));

endmodule

`default_nettype wire

// File: dv/predecModel.svh
`ifndef predecModelSvh
`define predecModelSvh

// Opcode ranges on the low byte of the first parcel.
function automatic instrClassE refClass(parcelT p);
  int op;
  op = int'(p[7:0]);
  if (op <= 'h3f) return clsAlu;
  if (op <= 'h5f) return (op % 2 == 0) ? clsLoad : clsStore;
  if (op <= 'h6f) return clsShift;
  if (op <= 'h77) return clsMul;
  if (op >= 'ha0 && op <= 'hb5) return clsJump;
  if (op == 'hff) return clsSys;
  return clsNone;
endfunction

// Valid start at k, optionally only jump starts.
function automatic logic refMarked(bundleT b, parcelMaskT e, int off, logic jumpOnly, int k);
  if (k < off) return 1'b0;
  if (k > 0 && !e[k-1]) return 1'b0;  // Previous parcel must end an instruction.
  if (!(|(e >> k))) return 1'b0;      // Must complete inside the bundle.
  return !jumpOnly || refClass(b[k]) == clsJump;
endfunction

function automatic int refCount(bundleT b, parcelMaskT e, int off, logic jumpOnly);
  int cnt;
  cnt = 0;
  for (int k = 0; k < NumParcels; k++) begin
    if (refMarked(b, e, off, jumpOnly, k)) cnt++;
  end
  return cnt;
endfunction

// Slot n holds the n-th marked start in parcel order.
function automatic slotT refSlot(bundleT b, parcelMaskT e, int off, logic jumpOnly, int n);
  slotT s;
  int   seen;
  s    = '0;
  seen = 0;
  for (int k = 0; k < NumParcels; k++) begin
    if (refMarked(b, e, off, jumpOnly, k)) begin
      if (seen == n) begin
        s.valid = 1'b1;
        s.cls   = refClass(b[k]);
        s.off   = OffW'(k);
        for (int i = 0; i < 3; i++) begin
          if (k + i < NumParcels) s.instr[i*ParcelW +: ParcelW] = b[k+i];
        end
      end
      seen++;
    end
  end
  return s;
endfunction

`endif

// File: dv/predecTb.sv
`timescale 1ns/1ps
`default_nettype none

module predecTb;

  import predecPkg::*;

  `include "predecModel.svh"

  logic                    clk;
  logic                    rstN;
  logic                    inValid;
  bundleT                  bundle;
  parcelMaskT              endBits;
  logic [OffW-1:0]         startOff;
  logic                    outValid;
  slotT [NumSlots-1:0]     slots;
  slotT [NumJumpSlots-1:0] jumpSlots;
  logic                    hasJumps;
  logic                    error;
  logic                    jumpOverflow;
  logic [15:0]             lfsr;

  predecoder dut0 (
    .clk          (clk),
    .rstN         (rstN),
    .inValid      (inValid),
    .bundle       (bundle),
    .endBits      (endBits),
    .startOff     (startOff),
    .outValid     (outValid),
    .slots        (slots),
    .jumpSlots    (jumpSlots),
    .hasJumps     (hasJumps),
    .error        (error),
    .jumpOverflow (jumpOverflow)
  );

  always #2 clk = ~clk;

  // Taps 16, 14, 13, 11.
  function automatic logic lfsrStep();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [127:0] randBits(int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[126:0], lfsrStep()};
    return v;
  endfunction

  task automatic abortRun(string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Stopped at first error.");
  endtask

  task automatic checkEq(string name, logic [63:0] expV, logic [63:0] actV);
    assert (actV === expV) else begin
      abortRun($sformatf("FAIL %s: expected %h, actual %h", name, expV, actV));
    end
  endtask

  task automatic checkOutputs(string name, bundleT b, parcelMaskT e, int off);
    int starts;
    int jumps;
    starts = refCount(b, e, off, 1'b0);
    jumps  = refCount(b, e, off, 1'b1);
    for (int n = 0; n < NumSlots; n++) begin
      checkEq($sformatf("%s slot%0d", name, n), 64'(refSlot(b, e, off, 1'b0, n)),
              64'(slots[n]));
    end
    for (int n = 0; n < NumJumpSlots; n++) begin
      checkEq($sformatf("%s jumpSlot%0d", name, n), 64'(refSlot(b, e, off, 1'b1, n)),
              64'(jumpSlots[n]));
    end
    checkEq($sformatf("%s hasJumps", name), 64'(jumps > 0), 64'(hasJumps));
    checkEq($sformatf("%s error", name), 64'(starts > NumSlots), 64'(error));
    checkEq($sformatf("%s jumpOverflow", name), 64'(jumps > NumJumpSlots),
            64'(jumpOverflow));
  endtask

  task automatic driveInputs(bundleT b, parcelMaskT e, int off);
    @(negedge clk);
    bundle   = b;
    endBits  = e;
    startOff = OffW'(off);
    inValid  = 1'b1;
  endtask

  // One strobe, then wait for the result.
  task automatic runCase(string name, bundleT b, parcelMaskT e, int off);
    int waitCyc;
    driveInputs(b, e, off);
    @(negedge clk);
    inValid = 1'b0;
    waitCyc = 0;
    while (!outValid && waitCyc < 10) begin
      @(negedge clk);
      waitCyc++;
    end
    assert (outValid) else abortRun($sformatf("Timeout waiting for outValid in %s", name));
    checkEq($sformatf("%s latency", name), 64'(0), 64'(waitCyc));
    checkOutputs(name, b, e, off);
  endtask

  task automatic testReset();
    checkEq("reset flags", 64'(0), 64'({outValid, hasJumps, error, jumpOverflow}));
    for (int n = 0; n < NumSlots; n++) begin
      checkEq($sformatf("reset slot%0d valid", n), 64'(0), 64'(slots[n].valid));
    end
    for (int n = 0; n < NumJumpSlots; n++) begin
      checkEq($sformatf("reset jumpSlot%0d valid", n), 64'(0), 64'(jumpSlots[n].valid));
    end
  endtask

  task automatic testClassDecode();
    logic [63:0] opSets [2];
    bundleT      b;
    opSets[0] = 64'hff_a7_75_63_4b_44_12_80;  // Byte k is the opcode at parcel k.
    opSets[1] = 64'hb6_b5_78_77_6f_40_5f_3f;  // Range edges.
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < NumParcels; k++) b[k] = {8'(k + 16 * s), opSets[s][k*8 +: 8]};
      runCase($sformatf("class set%0d off0", s), b, 8'hff, 0);
      runCase($sformatf("class set%0d off4", s), b, 8'hff, 4);
    end
  endtask

  task automatic testVarLength();
    parcelMaskT ends [3] = '{8'h65, 8'h92, 8'hc1};  // Last parcel of 8'h65 is open.
    bundleT     b;
    b = bundleT'(randBits(128));
    for (int i = 0; i < 3; i++) begin
      for (int off = 0; off < NumParcels; off++) begin
        runCase($sformatf("length e%0d off%0d", i, off), b, ends[i], off);
      end
    end
  endtask

  task automatic testJumps();
    parcelMaskT jumpPos [4] = '{8'h00, 8'h20, 8'h44, 8'h8a};
    bundleT     b;
    for (int j = 0; j < 4; j++) begin
      for (int k = 0; k < NumParcels; k++) b[k] = {8'(k), jumpPos[j][k] ? 8'ha3 : 8'h21};
      runCase($sformatf("jumps %0d", j), b, 8'hff, 0);
    end
  endtask

  // Two back-to-back strobes, then hold.
  task automatic testLatency();
    bundleT bA;
    bundleT bB;
    bA = bundleT'(randBits(128));
    bB = bundleT'(randBits(128));
    driveInputs(bA, 8'h55, 0);
    driveInputs(bB, 8'hf0, 1);
    checkEq("latency A outValid", 64'(1), 64'(outValid));
    checkOutputs("latency A", bA, 8'h55, 0);
    @(negedge clk);
    inValid = 1'b0;
    checkEq("latency B outValid", 64'(1), 64'(outValid));
    checkOutputs("latency B", bB, 8'hf0, 1);
    repeat (3) begin
      @(negedge clk);
      checkEq("hold outValid", 64'(0), 64'(outValid));
      checkOutputs("hold", bB, 8'hf0, 1);
    end
  endtask

  task automatic testRandom();
    logic [127:0] r;
    bundleT       b;
    parcelMaskT   e;
    int           off;
    for (int i = 0; i < 50; i++) begin
      b   = bundleT'(randBits(128));
      r   = randBits(8);
      e   = r[7:0];
      r   = randBits(3);
      off = int'(r[2:0]);
      runCase($sformatf("random %0d", i), b, e, off);
    end
  endtask

  initial begin
    clk      = 1'b0;
    rstN     = 1'b0;
    inValid  = 1'b0;
    bundle   = '0;
    endBits  = '0;
    startOff = '0;
    lfsr     = 16'd86;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    testReset();
    testClassDecode();
    testVarLength();
    testJumps();
    testLatency();
    testRandom();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: predecoder.f
+incdir+dv
design/predecPkg.sv
design/instrClassify.sv
design/startCounter.sv
design/slotSelect.sv
design/predecoder.sv
dv/predecTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the predecoder testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f predecoder.f --top-module predecTb -o predecSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/predecSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "All checks passed" sim.log; then
  exit 0
fi
exit 1
